/* hw/feeder_pkg.sv */
package feeder_pkg;

    // Bank data word, also the Wishbone data width
    typedef logic [63:0] sram_word_t;

    // Bank word address and every router setting
    typedef logic [7:0] sram_addr_t;

    // Host word address, bits 9:8 pick the region
    typedef logic [9:0] wb_adr_t;

    // Address regions
    localparam logic [1:0] RGN_WEIGHT = 2'd0;
    localparam logic [1:0] RGN_INPUT  = 2'd1;
    localparam logic [1:0] RGN_REGS   = 2'd2;
    localparam logic [1:0] RGN_NONE   = 2'd3;

    // Register indices within the register region
    typedef enum logic [2:0] {
        REG_IN_START,
        REG_KSIZE,
        REG_OSIZE,
        REG_STRIDE,
        REG_W_START,
        REG_W_OFFSET,
        REG_CTRL
    } reg_idx_e;

    // Control write bits and status read bits
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_CLEAR_BIT = 1;
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_DONE_BIT  = 1;

    // Route controller states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DRAIN,
        ST_DONE
    } ctrl_state_e;

endpackage

/* hw/sram_bank.sv */
`timescale 1ns/100ps

module sram_bank
    import feeder_pkg::*;
#(
    parameter int SRAM_WORDS = 256
) (
    input  logic       i_clk,
    input  logic       i_we,
    input  sram_addr_t i_addr,
    input  sram_word_t i_wdata,
    input  logic       i_re,
    output sram_word_t o_rdata
);
    localparam int AW = $clog2(SRAM_WORDS);

    sram_word_t       mem [SRAM_WORDS];
    logic [AW-1:0]    idx;

    // Upper address bits are ignored for small banks
    assign idx = i_addr[AW-1:0];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[idx] <= i_wdata;
        end
        // One-cycle read latency
        if (i_re) begin
            o_rdata <= mem[idx];
        end
    end

endmodule

/* hw/wb_config_regs.sv */
`timescale 1ns/100ps

module wb_config_regs
    import feeder_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_nrst,
    input  logic       i_wb_cyc,
    input  logic       i_wb_stb,
    input  logic       i_wb_we,
    input  wb_adr_t    i_wb_adr,
    input  sram_word_t i_wb_dat,
    input  logic       i_busy,
    input  logic       i_done,
    output sram_word_t o_wb_dat,
    output logic       o_wb_ack,
    output logic       o_wt_we,
    output logic       o_in_we,
    output sram_addr_t o_wr_addr,
    output sram_word_t o_wr_data,
    output sram_addr_t o_in_start,
    output sram_addr_t o_ksize,
    output sram_addr_t o_osize,
    output sram_addr_t o_stride,
    output sram_addr_t o_w_start,
    output sram_addr_t o_w_offset,
    output logic       o_start,
    output logic       o_clear
);
    logic       wb_req;
    logic       wr_acc;
    logic       reg_wr;
    logic [1:0] region;
    reg_idx_e   reg_idx;

    assign wb_req  = i_wb_cyc & i_wb_stb;
    assign region  = i_wb_adr[9:8];
    assign reg_idx = reg_idx_e'(i_wb_adr[2:0]);

    // One registered ack per request until stb drops or persists into a new cycle
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= wb_req & ~o_wb_ack;
        end
    end

    // Writes land on the acked cycle
    assign wr_acc = o_wb_ack & wb_req & i_wb_we;
    assign reg_wr = wr_acc & (region == RGN_REGS);

    assign o_wt_we   = wr_acc & (region == RGN_WEIGHT);
    assign o_in_we   = wr_acc & (region == RGN_INPUT);
    assign o_wr_addr = i_wb_adr[7:0];
    assign o_wr_data = i_wb_dat;

    // Control bits become one-cycle pulses
    assign o_start = reg_wr & (reg_idx == REG_CTRL) & i_wb_dat[CTRL_START_BIT];
    assign o_clear = reg_wr & (reg_idx == REG_CTRL) & i_wb_dat[CTRL_CLEAR_BIT];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_in_start <= '0;
            o_ksize    <= 8'd1;
            o_osize    <= 8'd1;
            o_stride   <= '0;
            o_w_start  <= '0;
            o_w_offset <= '0;
        end else if (reg_wr) begin
            case (reg_idx)
                REG_IN_START: o_in_start <= i_wb_dat[7:0];
                REG_KSIZE:    o_ksize    <= i_wb_dat[7:0];
                REG_OSIZE:    o_osize    <= i_wb_dat[7:0];
                REG_STRIDE:   o_stride   <= i_wb_dat[7:0];
                REG_W_START:  o_w_start  <= i_wb_dat[7:0];
                REG_W_OFFSET: o_w_offset <= i_wb_dat[7:0];
                default: ;
            endcase
        end
    end

    // Banks and the unmapped region read back as zero
    always_comb begin
        o_wb_dat = '0;
        case (region)
            RGN_REGS: begin
                case (reg_idx)
                    REG_IN_START: o_wb_dat[7:0] = o_in_start;
                    REG_KSIZE:    o_wb_dat[7:0] = o_ksize;
                    REG_OSIZE:    o_wb_dat[7:0] = o_osize;
                    REG_STRIDE:   o_wb_dat[7:0] = o_stride;
                    REG_W_START:  o_wb_dat[7:0] = o_w_start;
                    REG_W_OFFSET: o_wb_dat[7:0] = o_w_offset;
                    REG_CTRL: begin
                        o_wb_dat[STAT_BUSY_BIT] = i_busy;
                        o_wb_dat[STAT_DONE_BIT] = i_done;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

/* hw/input_router.sv */
`timescale 1ns/100ps

module input_router
    import feeder_pkg::*;
#(
    parameter int SRAM_WORDS = 256
) (
    input  logic       i_clk,
    input  logic       i_nrst,
    input  logic       i_clear,
    input  logic       i_we,
    input  sram_addr_t i_wr_addr,
    input  sram_word_t i_wr_data,
    input  sram_addr_t i_start_addr,
    input  sram_addr_t i_ksize,
    input  sram_addr_t i_osize,
    input  sram_addr_t i_stride,
    input  logic       i_step,
    output sram_word_t o_rd_data,
    output logic       o_window_end,
    output logic       o_last
);
    logic       active_q;
    sram_addr_t base_q;
    sram_addr_t tap_q;
    sram_addr_t win_q;
    sram_addr_t cur_base;
    sram_addr_t rd_addr;
    sram_addr_t bank_addr;
    logic       tap_last;
    logic       win_last;

    // Base tracks the setting until the first step of a run
    assign cur_base = active_q ? base_q : i_start_addr;
    assign rd_addr  = cur_base + tap_q;

    assign tap_last = (tap_q == i_ksize - 8'd1);
    assign win_last = (win_q == i_osize - 8'd1);

    assign o_window_end = i_step & tap_last;
    assign o_last       = i_step & tap_last & win_last;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            active_q <= 1'b0;
            base_q   <= '0;
            tap_q    <= '0;
            win_q    <= '0;
        end else if (i_clear) begin
            active_q <= 1'b0;
            tap_q    <= '0;
            win_q    <= '0;
        end else if (i_step) begin
            if (o_last) begin
                // Run finished, next run reloads from start_addr
                active_q <= 1'b0;
                tap_q    <= '0;
                win_q    <= '0;
            end else if (tap_last) begin
                active_q <= 1'b1;
                base_q   <= cur_base + i_stride;
                tap_q    <= '0;
                win_q    <= win_q + 8'd1;
            end else begin
                active_q <= 1'b1;
                base_q   <= cur_base;
                tap_q    <= tap_q + 8'd1;
            end
        end
    end

    // Host writes only happen while idle
    assign bank_addr = i_we ? i_wr_addr : rd_addr;

    sram_bank #(
        .SRAM_WORDS(SRAM_WORDS)
    ) u_bank (
        .i_clk  (i_clk),
        .i_we   (i_we),
        .i_addr (bank_addr),
        .i_wdata(i_wr_data),
        .i_re   (i_step),
        .o_rdata(o_rd_data)
    );

endmodule

/* hw/weight_router.sv */
`timescale 1ns/100ps

module weight_router
    import feeder_pkg::*;
#(
    parameter int SRAM_WORDS = 256
) (
    input  logic       i_clk,
    input  logic       i_nrst,
    input  logic       i_clear,
    input  logic       i_we,
    input  sram_addr_t i_wr_addr,
    input  sram_word_t i_wr_data,
    input  sram_addr_t i_start_addr,
    input  sram_addr_t i_addr_offset,
    input  logic       i_step,
    input  logic       i_reuse,
    output sram_word_t o_rd_data
);
    logic       active_q;
    sram_addr_t addr_q;
    sram_addr_t rd_addr;
    sram_addr_t bank_addr;

    // Outside a window the address is w_start itself
    assign rd_addr = active_q ? addr_q : i_start_addr;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            active_q <= 1'b0;
            addr_q   <= '0;
        end else if (i_clear) begin
            active_q <= 1'b0;
        end else if (i_step) begin
            if (i_reuse) begin
                // Window done, same weights again for the next one
                active_q <= 1'b0;
            end else begin
                active_q <= 1'b1;
                addr_q   <= rd_addr + i_addr_offset;
            end
        end
    end

    assign bank_addr = i_we ? i_wr_addr : rd_addr;

    sram_bank #(
        .SRAM_WORDS(SRAM_WORDS)
    ) u_bank (
        .i_clk  (i_clk),
        .i_we   (i_we),
        .i_addr (bank_addr),
        .i_wdata(i_wr_data),
        .i_re   (i_step),
        .o_rdata(o_rd_data)
    );

endmodule

/* hw/route_controller.sv */
`timescale 1ns/100ps

module route_controller
    import feeder_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_nrst,
    input  logic       i_clear,
    input  logic       i_start,
    input  sram_word_t i_in_data,
    input  sram_word_t i_wt_data,
    input  logic       i_last,
    input  logic       i_pair_ready,
    output logic       o_step,
    output logic       o_busy,
    output logic       o_done,
    output logic       o_pair_valid,
    output sram_word_t o_in_data,
    output sram_word_t o_wt_data,
    output logic       o_pair_last
);
    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        inflight_q;
    logic        last_q;
    sram_word_t  in_mem [2];
    sram_word_t  wt_mem [2];
    logic        last_mem [2];
    logic        wr_ptr_q;
    logic        rd_ptr_q;
    logic [1:0]  count_q;
    logic        push;
    logic        pop;
    logic        room;

    assign push = inflight_q;
    assign pop  = o_pair_valid & i_pair_ready;

    // Reads in flight plus buffered pairs stay at two or less
    assign room   = (({1'b0, inflight_q} + count_q) < 2'd2) | pop;
    assign o_step = (state_q == ST_RUN) & room;

    assign o_busy = (state_q == ST_RUN) | (state_q == ST_DRAIN);
    assign o_done = (state_q == ST_DONE);

    // Head of the pair buffer
    assign o_pair_valid = (count_q != 2'd0);
    assign o_in_data    = in_mem[rd_ptr_q];
    assign o_wt_data    = wt_mem[rd_ptr_q];
    assign o_pair_last  = last_mem[rd_ptr_q];

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE, ST_DONE: if (i_start) state_d = ST_RUN;
            ST_RUN:           if (o_step && i_last) state_d = ST_DRAIN;
            ST_DRAIN:         if (pop && o_pair_last) state_d = ST_DONE;
            default:          state_d = ST_IDLE;
        endcase
        if (i_clear) begin
            state_d = ST_IDLE;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q    <= ST_IDLE;
            inflight_q <= 1'b0;
            last_q     <= 1'b0;
            wr_ptr_q   <= 1'b0;
            rd_ptr_q   <= 1'b0;
            count_q    <= 2'd0;
        end else begin
            state_q <= state_d;
            if (i_clear) begin
                // Drop anything in flight or buffered
                inflight_q <= 1'b0;
                last_q     <= 1'b0;
                wr_ptr_q   <= 1'b0;
                rd_ptr_q   <= 1'b0;
                count_q    <= 2'd0;
            end else begin
                inflight_q <= o_step;
                last_q     <= o_step & i_last;
                if (push) begin
                    wr_ptr_q <= ~wr_ptr_q;
                end
                if (pop) begin
                    rd_ptr_q <= ~rd_ptr_q;
                end
                case ({push, pop})
                    2'b10:   count_q <= count_q + 2'd1;
                    2'b01:   count_q <= count_q - 2'd1;
                    default: count_q <= count_q;
                endcase
            end
        end
    end

    // Bank data arrives one cycle after the step
    always_ff @(posedge i_clk) begin
        if (push) begin
            in_mem[wr_ptr_q]   <= i_in_data;
            wt_mem[wr_ptr_q]   <= i_wt_data;
            last_mem[wr_ptr_q] <= last_q;
        end
    end

endmodule

/* hw/feeder_top.sv */
`timescale 1ns/100ps

module feeder_top
    import feeder_pkg::*;
#(
    parameter int SRAM_WORDS = 256
) (
    input  logic       i_clk,
    input  logic       i_nrst,
    input  logic       i_wb_cyc,
    input  logic       i_wb_stb,
    input  logic       i_wb_we,
    input  wb_adr_t    i_wb_adr,
    input  sram_word_t i_wb_dat,
    output sram_word_t o_wb_dat,
    output logic       o_wb_ack,
    output logic       o_pair_valid,
    output sram_word_t o_in_data,
    output sram_word_t o_wt_data,
    output logic       o_pair_last,
    input  logic       i_pair_ready
);
    logic       wt_we;
    logic       in_we;
    sram_addr_t wr_addr;
    sram_word_t wr_data;
    sram_addr_t in_start;
    sram_addr_t ksize;
    sram_addr_t osize;
    sram_addr_t stride;
    sram_addr_t w_start;
    sram_addr_t w_offset;
    logic       start;
    logic       clear;
    logic       step;
    logic       window_end;
    logic       last;
    logic       busy;
    logic       done;
    sram_word_t in_rd_data;
    sram_word_t wt_rd_data;

    wb_config_regs u_regs (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_wb_cyc  (i_wb_cyc),
        .i_wb_stb  (i_wb_stb),
        .i_wb_we   (i_wb_we),
        .i_wb_adr  (i_wb_adr),
        .i_wb_dat  (i_wb_dat),
        .i_busy    (busy),
        .i_done    (done),
        .o_wb_dat  (o_wb_dat),
        .o_wb_ack  (o_wb_ack),
        .o_wt_we   (wt_we),
        .o_in_we   (in_we),
        .o_wr_addr (wr_addr),
        .o_wr_data (wr_data),
        .o_in_start(in_start),
        .o_ksize   (ksize),
        .o_osize   (osize),
        .o_stride  (stride),
        .o_w_start (w_start),
        .o_w_offset(w_offset),
        .o_start   (start),
        .o_clear   (clear)
    );

    input_router #(
        .SRAM_WORDS(SRAM_WORDS)
    ) u_input_router (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_clear     (clear),
        .i_we        (in_we),
        .i_wr_addr   (wr_addr),
        .i_wr_data   (wr_data),
        .i_start_addr(in_start),
        .i_ksize     (ksize),
        .i_osize     (osize),
        .i_stride    (stride),
        .i_step      (step),
        .o_rd_data   (in_rd_data),
        .o_window_end(window_end),
        .o_last      (last)
    );

    weight_router #(
        .SRAM_WORDS(SRAM_WORDS)
    ) u_weight_router (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_clear      (clear),
        .i_we         (wt_we),
        .i_wr_addr    (wr_addr),
        .i_wr_data    (wr_data),
        .i_start_addr (w_start),
        .i_addr_offset(w_offset),
        .i_step       (step),
        .i_reuse      (window_end),
        .o_rd_data    (wt_rd_data)
    );

    route_controller u_route_controller (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_clear     (clear),
        .i_start     (start),
        .i_in_data   (in_rd_data),
        .i_wt_data   (wt_rd_data),
        .i_last      (last),
        .i_pair_ready(i_pair_ready),
        .o_step      (step),
        .o_busy      (busy),
        .o_done      (done),
        .o_pair_valid(o_pair_valid),
        .o_in_data   (o_in_data),
        .o_wt_data   (o_wt_data),
        .o_pair_last (o_pair_last)
    );

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic o_clk
);
    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0);
            o_clk = ~o_clk;
        end
    end

endmodule

/* sim/feeder_properties.sv */
`timescale 1ns/100ps

module feeder_properties
    import feeder_pkg::*;
(
    input logic       i_clk,
    input logic       i_nrst,
    input logic       i_clear,
    input logic       i_wb_ack,
    input logic       i_step,
    input logic       i_inflight,
    input logic [1:0] i_count,
    input logic       i_pair_valid,
    input logic       i_pair_ready,
    input sram_word_t i_in_data,
    input sram_word_t i_wt_data,
    input logic       i_pair_last
);

    // Ack lasts a single cycle
    ack_single: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_wb_ack |=> !i_wb_ack)
        else $error("Wishbone ack high for two consecutive cycles");

    // Buffered pairs plus reads in flight
    occupancy: assert property (@(posedge i_clk) disable iff (!i_nrst)
        ({2'b0, i_inflight} + {1'b0, i_count}) <= 3'd2)
        else $error("pair buffer and in-flight reads exceed two");

    // Held pair under back-pressure
    held_stable: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_pair_valid && !i_pair_ready && !i_clear) |=>
        (i_pair_valid && $stable(i_in_data) && $stable(i_wt_data) && $stable(i_pair_last)))
        else $error("pair changed or vanished while ready was low");

    // Valid follows a step by two cycles
    valid_after_step: assert property (@(posedge i_clk) disable iff (!i_nrst)
        $rose(i_pair_valid) |-> $past(i_step, 2))
        else $error("valid rose without a step two cycles earlier");

endmodule

/* sim/feeder_tb.sv */
`timescale 1ns/100ps

module feeder_tb
    import feeder_pkg::*;
;
    localparam wb_adr_t CTRL_ADR    = {RGN_REGS, 5'd0, REG_CTRL};
    localparam int      ACK_LIMIT   = 16;
    localparam int      LAT_LIMIT   = 16;
    localparam int      DRAIN_LIMIT = 1000;

    logic       clk;
    logic       nrst;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    wb_adr_t    wb_adr;
    sram_word_t wb_dat_w;
    sram_word_t wb_dat_r;
    logic       wb_ack;
    logic       pair_valid;
    sram_word_t in_data;
    sram_word_t wt_data;
    logic       pair_last;
    logic       pair_ready;

    // Ready pattern set by the stimulus
    logic        rdy_mode;
    logic [31:0] rdy_mask;

    // Host view of both banks
    sram_word_t shadow_in [256];
    sram_word_t shadow_wt [256];

    sram_word_t exp_in[$];
    sram_word_t exp_wt[$];
    logic       exp_last[$];

    int cmd_errs;
    int timeouts;
    int pair_errs = 0;
    int pairs_checked = 0;

    tb_clock_gen #(
        .PERIOD_NS(4.0)
    ) u_clock_gen (
        .o_clk(clk)
    );

    feeder_top #(
        .SRAM_WORDS(64)
    ) u_feeder_top (
        .i_clk       (clk),
        .i_nrst      (nrst),
        .i_wb_cyc    (wb_cyc),
        .i_wb_stb    (wb_stb),
        .i_wb_we     (wb_we),
        .i_wb_adr    (wb_adr),
        .i_wb_dat    (wb_dat_w),
        .o_wb_dat    (wb_dat_r),
        .o_wb_ack    (wb_ack),
        .o_pair_valid(pair_valid),
        .o_in_data   (in_data),
        .o_wt_data   (wt_data),
        .o_pair_last (pair_last),
        .i_pair_ready(pair_ready)
    );

    bind feeder_top feeder_properties u_props (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_clear     (clear),
        .i_wb_ack    (o_wb_ack),
        .i_step      (step),
        .i_inflight  (u_route_controller.inflight_q),
        .i_count     (u_route_controller.count_q),
        .i_pair_valid(o_pair_valid),
        .i_pair_ready(i_pair_ready),
        .i_in_data   (o_in_data),
        .i_wt_data   (o_wt_data),
        .i_pair_last (o_pair_last)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Bank fill word unique to each host address
    function automatic sram_word_t fill_word(input wb_adr_t adr);
        logic [31:0] mix;
        mix = 32'h9e3779b9 * {22'd0, adr};
        return {adr, 22'h2d5a5a, mix};
    endfunction

    task automatic wb_access(input logic we, input wb_adr_t adr, input sram_word_t dat,
                             output sram_word_t rdat);
        int n;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        n = 0;
        do begin
            @(posedge clk);
            #0.5;
            n++;
        end while (!wb_ack && n < ACK_LIMIT);
        assert (wb_ack) else begin
            timeouts++;
            $display("no Wishbone ack for address %h", adr);
        end
        rdat = wb_dat_r;
        // The transfer completes on the edge that ends the ack cycle
        @(posedge clk);
        #0.5;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input wb_adr_t adr, input sram_word_t dat);
        sram_word_t ignored;
        wb_access(1'b1, adr, dat, ignored);
        if (adr[9:8] == RGN_WEIGHT) begin
            shadow_wt[adr[7:0]] = dat;
        end else if (adr[9:8] == RGN_INPUT) begin
            shadow_in[adr[7:0]] = dat;
        end
    endtask

    task automatic wb_read_check(input wb_adr_t adr, input sram_word_t exp);
        sram_word_t got;
        wb_access(1'b0, adr, '0, got);
        assert (got == exp) else begin
            cmd_errs++;
            $display("FAILED o_wb_dat at %h got %h expected %h", adr, got, exp);
        end
    endtask

    task automatic fill_banks(input int words);
        for (int i = 0; i < words; i++) begin
            wb_write({RGN_WEIGHT, i[7:0]}, fill_word({RGN_WEIGHT, i[7:0]}));
            wb_write({RGN_INPUT, i[7:0]}, fill_word({RGN_INPUT, i[7:0]}));
        end
    endtask

    // Expected pairs of one window with consecutive inputs and strided weights
    task automatic push_window(input sram_addr_t in_addr, input sram_addr_t wt_addr,
                               input sram_addr_t wt_step, input sram_addr_t taps,
                               input logic last);
        sram_addr_t ia;
        sram_addr_t wa;
        for (int t = 0; t < int'(taps); t++) begin
            ia = in_addr + t[7:0];
            wa = wt_addr + wt_step * t[7:0];
            exp_in.push_back(shadow_in[ia]);
            exp_wt.push_back(shadow_wt[wa]);
            exp_last.push_back(last && (t == int'(taps) - 1));
        end
    endtask

    task automatic set_ready(input logic mode, input logic [31:0] mask);
        @(posedge clk);
        rdy_mode = mode;
        rdy_mask = mask;
        #0.5;
    endtask

    // Start and time the first valid and the back-to-back stream
    task automatic start_and_time(input int lat, input int pairs);
        int n;
        int got;
        wb_write(CTRL_ADR, 64'h1);
        // Ack was seen one cycle before the write returned
        n = 1;
        do begin
            @(posedge clk);
            #0.5;
            n++;
        end while (!pair_valid && n < LAT_LIMIT);
        assert (n == lat) else begin
            cmd_errs++;
            $display("FAILED o_pair_valid rose after %h cycles expected %h", n, lat);
        end
        got = 0;
        while (pair_valid && got < pairs) begin
            got++;
            if (got < pairs) begin
                @(posedge clk);
                #0.5;
            end
        end
        assert (got == pairs) else begin
            cmd_errs++;
            $display("pair stream stalled after %0d of %0d pairs", got, pairs);
        end
    endtask

    task automatic check_valid(input logic exp);
        @(posedge clk);
        #0.5;
        assert (pair_valid == exp) else begin
            cmd_errs++;
            $display("FAILED o_pair_valid got %h expected %h", pair_valid, exp);
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_in.size() != 0 && n < DRAIN_LIMIT) begin
            @(posedge clk);
            #0.5;
            n++;
        end
        assert (exp_in.size() == 0) else begin
            timeouts++;
            $display("timed out with %0d expected pairs not received", exp_in.size());
        end
    endtask

    task automatic run_stim_file();
        int         fd;
        int         c;
        int         rc;
        logic [7:0] ch;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] d;
        logic [63:0] e;
        logic [63:0] f;
        fd = $fopen("sim/feeder_stim.txt", "r");
        assert (fd != 0) else begin
            cmd_errs++;
            $display("cannot open the stimulus file");
        end
        if (fd == 0) begin
            return;
        end
        c = $fgetc(fd);
        while (c != -1) begin
            ch = c[7:0];
            rc = 1;
            case (ch)
                "#": begin
                    while (c != -1 && c != 10) begin
                        c = $fgetc(fd);
                    end
                end
                "F": begin
                    rc = $fscanf(fd, "%h", a);
                    fill_banks(int'(a[7:0]));
                end
                "W": begin
                    rc = $fscanf(fd, "%h %h", a, b);
                    wb_write(a[9:0], b);
                end
                "R": begin
                    rc = $fscanf(fd, "%h %h", a, b);
                    wb_read_check(a[9:0], b);
                end
                "M": begin
                    rc = $fscanf(fd, "%h %h", a, b);
                    set_ready(a[0], b[31:0]);
                end
                "E": begin
                    rc = $fscanf(fd, "%h %h %h %h %h", a, b, d, e, f);
                    push_window(a[7:0], b[7:0], d[7:0], e[7:0], f[0]);
                end
                "L": begin
                    rc = $fscanf(fd, "%h %h", a, b);
                    start_and_time(int'(a[7:0]), int'(b[7:0]));
                end
                "Y": begin
                    rc = $fscanf(fd, "%h", a);
                    repeat (int'(a[7:0])) @(posedge clk);
                    #0.5;
                end
                "V": begin
                    rc = $fscanf(fd, "%h", a);
                    check_valid(a[0]);
                end
                "S": wb_write(CTRL_ADR, 64'h1);
                "C": wb_write(CTRL_ADR, 64'h2);
                "D": wait_drained();
                " ", "\n", "\r", "\t": ;
                default: begin
                    assert (1'b0) else begin
                        cmd_errs++;
                        $display("unknown command character %h in the stimulus file", ch);
                    end
                end
            endcase
            assert (rc > 0) else begin
                cmd_errs++;
                $display("stimulus command %h has missing or unreadable operands", ch);
            end
            if (c != -1) begin
                c = $fgetc(fd);
            end
        end
        $fclose(fd);
    endtask

    // Ready driver from a fixed mask or the LCG
    initial begin
        logic [31:0] lcg_state;
        logic [4:0]  rdy_pos;
        lcg_state  = 32'h0e93365e;
        rdy_pos    = '0;
        pair_ready = 1'b0;
        forever begin
            @(posedge clk);
            #0.5;
            if (rdy_mode) begin
                lcg_state  = lcg_next(lcg_state);
                pair_ready = lcg_state[27];
            end else begin
                pair_ready = rdy_mask[rdy_pos];
                rdy_pos    = rdy_pos + 5'd1;
            end
        end
    end

    // Pair checker, looks mid-cycle at the pair that the next edge transfers
    initial begin
        forever begin
            @(negedge clk);
            if (pair_valid && pair_ready) begin
                assert (exp_in.size() != 0) else begin
                    pair_errs++;
                    $display("a pair was transferred with no expected pair left");
                end
                if (exp_in.size() != 0) begin
                    assert (in_data == exp_in[0]) else begin
                        pair_errs++;
                        $display("FAILED o_in_data got %h expected %h", in_data, exp_in[0]);
                    end
                    assert (wt_data == exp_wt[0]) else begin
                        pair_errs++;
                        $display("FAILED o_wt_data got %h expected %h", wt_data, exp_wt[0]);
                    end
                    assert (pair_last == exp_last[0]) else begin
                        pair_errs++;
                        $display("FAILED o_pair_last got %h expected %h",
                                 pair_last, exp_last[0]);
                    end
                    void'(exp_in.pop_front());
                    void'(exp_wt.pop_front());
                    void'(exp_last.pop_front());
                    pairs_checked++;
                end
            end
        end
    end

    initial begin
        nrst      = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        rdy_mode  = 1'b0;
        rdy_mask  = '0;
        cmd_errs  = 0;
        timeouts  = 0;
        repeat (4) @(posedge clk);
        #0.5;
        nrst = 1'b1;
        run_stim_file();
        $display("%0d pairs checked, %0d pair errors, %0d other errors, %0d timeouts",
                 pairs_checked, pair_errs, cmd_errs, timeouts);
        if (pair_errs == 0 && cmd_errs == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* sim/feeder_stim.txt */
# F n | W adr data | R adr expected | M mode mask (0 fixed, 1 LCG) | S start | C clear
# E in_addr wt_addr wt_step taps last | L latency pairs | Y cycles | V valid | D drain
F 20
W 200 5
W 201 3
W 202 4
W 203 1
W 204 2
W 205 1
R 201 3
M 0 ffffffff
E 05 02 1 3 0
E 06 02 1 3 0
E 07 02 1 3 0
E 08 02 1 3 1
L 3 0c
D
R 206 2
# stride 2, weights 4 apart, fixed ready mask
W 200 0a
W 202 3
W 203 2
W 204 10
W 205 4
M 0 6db6db6d
E 0a 10 4 3 0
E 0c 10 4 3 0
E 0e 10 4 3 1
S
D
R 206 2
# random ready back-pressure
W 200 5
W 202 4
W 203 1
W 204 2
W 205 1
M 1 0
E 05 02 1 3 0
E 06 02 1 3 0
E 07 02 1 3 0
E 08 02 1 3 1
S
R 206 1
D
R 206 2
# clear while stalled, then a clean run
M 0 0
S
Y 6
V 1
C
V 0
R 206 0
M 0 ffffffff
E 05 02 1 3 0
E 06 02 1 3 0
E 07 02 1 3 0
E 08 02 1 3 1
S
D
R 206 2

/* src.f */
hw/feeder_pkg.sv
hw/sram_bank.sv
hw/wb_config_regs.sv
hw/input_router.sv
hw/weight_router.sv
hw/route_controller.sv
hw/feeder_top.sv
sim/tb_clock_gen.sv
sim/feeder_properties.sv
sim/feeder_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = feeder_tb
FILELIST  = src.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q -F '*** PASSED ***'

clean:
	rm -rf obj_dir
